// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := aes_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/aes_tb.sv ====
module aes_tb;

	import aes_sizes_pkg::*;

	localparam int max_tests = 32;
	localparam int fields = 5; // op, key length, key, input block, expected block.
	localparam int done_wait = 40;

	logic                clk;
	logic                arst_n;
	logic                start;
	aes_op_t             op;
	key_len_t            key_len;
	logic [key_bits-1:0] key;
	logic [blk_bits-1:0] data_in;
	logic [blk_bits-1:0] data_out;
	logic                busy;
	logic                done;

	logic [key_bits-1:0] vec_mem [fields*max_tests];
	logic [blk_bits-1:0] held_out; // last block result that data_out must still show.
	int                  n_tests;
	int                  test_errors;
	int                  pass_count;
	int                  fail_count;
	int                  cycle_count = 0;
	int                  cycle_limit = 1000000;

	aes_top aes_top_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (start),
		.op       (op),
		.key_len  (key_len),
		.key      (key),
		.data_in  (data_in),
		.data_out (data_out),
		.busy     (busy),
		.done     (done)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_word(input logic [blk_bits-1:0] got, input logic [blk_bits-1:0] exp,
		input string what);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_int(input int got, input int exp, input string what);
		assert (got == exp) else begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			test_errors++;
		end
	endtask

	function automatic string describe_op(input aes_op_t o);
		case (o)
			op_encrypt: return "encrypt";
			op_decrypt: return "decrypt";
			default:    return "key expansion";
		endcase
	endfunction

	task automatic load_tests();
		$readmemh("bench/aes_tests.txt", vec_mem);
		n_tests = 0;
		while (n_tests < max_tests && vec_mem[fields*n_tests][3:0] != 4'hf)
			n_tests++; // op f closes the list.
		assert (n_tests > 0 && n_tests < max_tests) else begin
			$display("the test file did not give a closed list of tests");
			fail_count++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d errors", name, test_errors);
		end
	endtask

	task automatic run_test(input int idx);
		aes_op_t             t_op;
		key_len_t            t_len;
		logic [key_bits-1:0] t_key;
		logic [blk_bits-1:0] t_in;
		logic [blk_bits-1:0] t_exp;
		int                  want_lat;
		int                  lat;
		int                  extra_at;
		int                  gap;
		logic                seen;
		t_op = aes_op_t'(vec_mem[fields*idx][1:0]);
		t_len = key_len_t'(vec_mem[fields*idx+1][0]);
		t_key = vec_mem[fields*idx+2];
		t_in = vec_mem[fields*idx+3][blk_bits-1:0];
		t_exp = vec_mem[fields*idx+4][blk_bits-1:0];
		want_lat = ((t_len == key_len_256) ? nr_256 : nr_128) + 2;
		extra_at = $urandom_range(want_lat - 2, 1); // cycle of the ignored start.
		gap = $urandom_range(3, 0);
		test_errors = 0;
		repeat (gap) @(negedge clk);
		check_int(int'(busy), 0, "busy before start");
		start = 1'b1;
		op = t_op;
		key_len = t_len;
		key = t_key;
		data_in = t_in;
		@(negedge clk);
		start = 1'b0;
		key = {8{$urandom()}}; // key and block are only sampled with start.
		data_in = {4{$urandom()}};
		lat = 0;
		seen = 1'b0;
		while (!seen && lat < done_wait) begin
			check_int(int'(busy), 1, "busy while running");
			if (done) begin
				seen = 1'b1;
			end else begin
				start = (lat == extra_at);
				if (start) begin
					op = aes_op_t'(2'($urandom_range(2, 0)));
					key_len = key_len_t'(1'($urandom_range(1, 0)));
				end
				@(negedge clk);
				lat++;
			end
		end
		start = 1'b0;
		assert (seen) else begin
			$display("test %0d: done never came within %0d cycles of the start", idx + 1,
				done_wait);
			test_errors++;
		end
		if (seen) begin
			check_int(lat, want_lat, "cycles from start to done");
			if (t_op == op_key_exp) begin
				check_word(data_out, held_out, "data_out after key expansion");
			end else begin
				check_word(data_out, t_exp, "data_out");
				held_out = t_exp;
			end
			@(negedge clk);
			check_int(int'(done), 0, "done one cycle later");
			check_int(int'(busy), 0, "busy one cycle after done");
			check_word(data_out, held_out, "data_out held after done");
		end
		finish_test($sformatf("test %0d %s aes-%0d", idx + 1, describe_op(t_op),
			(t_len == key_len_256) ? 256 : 128));
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		op = op_key_exp;
		key_len = key_len_128;
		key = '0;
		data_in = '0;
		held_out = '0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(32'h3635_dc90));
		load_tests();
		cycle_limit = n_tests * 20 + 200;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		test_errors = 0;
		check_int(int'(busy), 0, "busy after reset");
		check_int(int'(done), 0, "done after reset");
		check_word(data_out, '0, "data_out after reset");
		@(negedge clk);
		check_int(int'(busy), 0, "busy after reset release");
		finish_test("reset values");
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== bench/aes_tests.txt ====
// op (0 key expansion, 1 encrypt, 2 decrypt), key length (0 aes-128, 1 aes-256),
// key (aes-128 in the upper half), input block, expected block; op f ends the list.
// fips-197 appendix c.1
0 0 000102030405060708090a0b0c0d0e0f00000000000000000000000000000000 0 0
1 0 0 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2 0 0 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
// fips-197 appendix b key
0 0 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 0 0
1 0 0 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
2 0 0 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
// fips-197 appendix c.3
0 1 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 0 0
1 1 0 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
2 1 0 8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff
// back to c.1, decrypt first on a fresh schedule
0 0 000102030405060708090a0b0c0d0e0f00000000000000000000000000000000 0 0
2 0 0 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
1 0 0 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
f 0 0 0 0

// ==== sim.f ====
source/aes_sizes_pkg.sv
source/aes_math_pkg.sv
source/round_key_ram.sv
source/key_expansion.sv
source/cipher.sv
source/decipher.sv
source/aes_top.sv
bench/aes_tb.sv

// ==== source/aes_math_pkg.sv ====
package aes_math_pkg;

	import aes_sizes_pkg::*;

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] acc;
		p = a;
		acc = 8'h00;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc = acc ^ p;
			p = xtime(p);
		end
		return acc;
	endfunction

	// a^254 also maps zero to zero.
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] p;
		logic [7:0] r;
		p = a;
		r = 8'h01;
		for (int i = 1; i < 8; i++) begin
			p = gf_mul(p, p);
			r = gf_mul(r, p);
		end
		return r;
	endfunction

	function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
		return (b << n) | (b >> (8 - n));
	endfunction

	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] b;
		b = gf_inv(a);
		return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
	endfunction

	function automatic logic [7:0] inv_sbox(input logic [7:0] a);
		return gf_inv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05);
	endfunction

	function automatic logic [7:0] rcon(input logic [3:0] i);
		logic [7:0] r;
		r = 8'h01;
		for (int k = 1; k < 16; k++) begin
			if (k < i)
				r = xtime(r);
		end
		return r;
	endfunction

	function automatic logic [word_bits-1:0] sub_word(input logic [word_bits-1:0] w);
		logic [word_bits-1:0] o;
		for (int i = 0; i < word_bits / 8; i++)
			o[8*i +: 8] = sbox(w[8*i +: 8]);
		return o;
	endfunction

	function automatic logic [word_bits-1:0] rot_word(input logic [word_bits-1:0] w);
		return {w[word_bits-9:0], w[word_bits-1 -: 8]};
	endfunction

	function automatic logic [blk_bits-1:0] sub_bytes(input logic [blk_bits-1:0] s);
		logic [blk_bits-1:0] o;
		for (int i = 0; i < blk_bits / 8; i++)
			o[8*i +: 8] = sbox(s[8*i +: 8]);
		return o;
	endfunction

	function automatic logic [blk_bits-1:0] inv_sub_bytes(input logic [blk_bits-1:0] s);
		logic [blk_bits-1:0] o;
		for (int i = 0; i < blk_bits / 8; i++)
			o[8*i +: 8] = inv_sbox(s[8*i +: 8]);
		return o;
	endfunction

	// byte 4c+r is row r of column c with byte 0 in the top bits.
	function automatic logic [blk_bits-1:0] shift_rows(input logic [blk_bits-1:0] s);
		logic [blk_bits-1:0] o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o[blk_bits-1-8*(4*c+r) -: 8] = s[blk_bits-1-8*(4*((c+r)%4)+r) -: 8];
		return o;
	endfunction

	function automatic logic [blk_bits-1:0] inv_shift_rows(input logic [blk_bits-1:0] s);
		logic [blk_bits-1:0] o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o[blk_bits-1-8*(4*c+r) -: 8] = s[blk_bits-1-8*(4*((c-r+4)%4)+r) -: 8];
		return o;
	endfunction

	function automatic logic [word_bits-1:0] mix_column(input logic [word_bits-1:0] w);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		{a0, a1, a2, a3} = w;
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	function automatic logic [word_bits-1:0] inv_mix_column(input logic [word_bits-1:0] w);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		{a0, a1, a2, a3} = w;
		return {gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09),
			gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d),
			gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b),
			gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e)};
	endfunction

	function automatic logic [blk_bits-1:0] mix_columns(input logic [blk_bits-1:0] s);
		logic [blk_bits-1:0] o;
		for (int c = 0; c < 4; c++)
			o[blk_bits-1-word_bits*c -: word_bits] =
				mix_column(s[blk_bits-1-word_bits*c -: word_bits]);
		return o;
	endfunction

	function automatic logic [blk_bits-1:0] inv_mix_columns(input logic [blk_bits-1:0] s);
		logic [blk_bits-1:0] o;
		for (int c = 0; c < 4; c++)
			o[blk_bits-1-word_bits*c -: word_bits] =
				inv_mix_column(s[blk_bits-1-word_bits*c -: word_bits]);
		return o;
	endfunction

endpackage

// ==== source/aes_sizes_pkg.sv ====
package aes_sizes_pkg;

	// data block and round key share one width.
	localparam int blk_bits = 128;

	// key port width; aes-128 keys occupy the upper half.
	localparam int key_bits = 256;

	localparam int word_bits = 32; // one key schedule word.

	// rounds per key length.
	localparam int nr_128 = 10;
	localparam int nr_256 = 14;

	// round-key storage, one entry per round key.
	localparam int addr_bits = 4;
	localparam int ram_depth = nr_256 + 1;

	typedef enum logic {
		key_len_128 = 1'b0,
		key_len_256 = 1'b1
	} key_len_t;

	typedef enum logic [1:0] {
		op_key_exp = 2'd0, // fill the round-key ram.
		op_encrypt = 2'd1,
		op_decrypt = 2'd2
	} aes_op_t;

endpackage

// ==== source/aes_top.sv ====
module aes_top (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               start,
	input  aes_sizes_pkg::aes_op_t             op,
	input  aes_sizes_pkg::key_len_t            key_len,
	input  logic [aes_sizes_pkg::key_bits-1:0] key,
	input  logic [aes_sizes_pkg::blk_bits-1:0] data_in,
	output logic [aes_sizes_pkg::blk_bits-1:0] data_out,
	output logic                               busy,
	output logic                               done
);

	import aes_sizes_pkg::*;

	aes_op_t              op_q;
	key_len_t             key_len_q;
	logic                 start_ok;
	logic                 kexp_start;
	logic                 enc_start;
	logic                 dec_start;
	logic [addr_bits-1:0] rounds;
	logic [addr_bits-1:0] ram_addr;
	logic [addr_bits-1:0] kexp_addr;
	logic [addr_bits-1:0] enc_addr;
	logic [addr_bits-1:0] dec_addr;
	logic [blk_bits-1:0]  ram_wdata;
	logic [blk_bits-1:0]  ram_rdata;
	logic                 ram_we;
	logic                 kexp_done;
	logic                 enc_done;
	logic                 dec_done;
	logic [blk_bits-1:0]  enc_data;
	logic [blk_bits-1:0]  dec_data;
	logic                 dec_last_q; // last finished block was a decrypt.
	logic                 out_dec;

	assign start_ok = start && !busy; // starts while busy are dropped.
	assign kexp_start = start_ok && (op == op_key_exp);
	assign enc_start = start_ok && (op == op_encrypt);
	assign dec_start = start_ok && (op == op_decrypt);

	assign rounds = (key_len_q == key_len_128) ? addr_bits'(nr_128) : addr_bits'(nr_256);

	always_comb begin
		case (op_q)
			op_encrypt: ram_addr = enc_addr;
			op_decrypt: ram_addr = dec_addr;
			default:    ram_addr = kexp_addr;
		endcase
	end

	round_key_ram key_ram_i (
		.clk   (clk),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.we    (ram_we),
		.rdata (ram_rdata)
	);

	key_expansion key_exp_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (kexp_start),
		.key_len (key_len_q),
		.key     (key),
		.wdata   (ram_wdata),
		.addr    (kexp_addr),
		.we      (ram_we),
		.done    (kexp_done)
	);

	cipher encrypt_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (enc_start),
		.rounds    (rounds),
		.data_in   (data_in),
		.round_key (ram_rdata),
		.key_addr  (enc_addr),
		.data_out  (enc_data),
		.done      (enc_done)
	);

	decipher decrypt_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (dec_start),
		.rounds    (rounds),
		.data_in   (data_in),
		.round_key (ram_rdata),
		.key_addr  (dec_addr),
		.data_out  (dec_data),
		.done      (dec_done)
	);

	// show the block that finished last, switching in its done cycle.
	assign out_dec = dec_done || (!enc_done && dec_last_q);
	assign data_out = out_dec ? dec_data : enc_data;

	assign done = kexp_done | enc_done | dec_done;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			op_q <= op_key_exp;
			key_len_q <= key_len_128;
			dec_last_q <= 1'b0;
		end else begin
			if (start_ok) begin
				busy <= 1'b1;
				op_q <= op;
				key_len_q <= key_len;
			end else if (done) begin
				busy <= 1'b0;
			end
			if (enc_done)
				dec_last_q <= 1'b0;
			else if (dec_done)
				dec_last_q <= 1'b1;
		end
	end

endmodule

// ==== source/cipher.sv ====
module cipher (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                start,
	input  logic [aes_sizes_pkg::addr_bits-1:0] rounds,
	input  logic [aes_sizes_pkg::blk_bits-1:0]  data_in,
	input  logic [aes_sizes_pkg::blk_bits-1:0]  round_key,
	output logic [aes_sizes_pkg::addr_bits-1:0] key_addr,
	output logic [aes_sizes_pkg::blk_bits-1:0]  data_out,
	output logic                                done
);

	import aes_sizes_pkg::*;
	import aes_math_pkg::*;

	logic [blk_bits-1:0]  state;
	logic [blk_bits-1:0]  sr_out;
	logic [blk_bits-1:0]  next_state;
	logic [addr_bits-1:0] cnt; // address presented to the ram.
	logic [addr_bits-1:0] rnd; // round whose key is on round_key.
	logic                 run;
	logic                 key_ok;
	logic                 last_rnd;

	assign key_addr = cnt;
	assign sr_out = shift_rows(sub_bytes(state));
	assign last_rnd = key_ok && (rnd == rounds);

	always_comb begin
		if (rnd == '0)
			next_state = state ^ round_key; // initial AddRoundKey.
		else if (rnd == rounds)
			next_state = sr_out ^ round_key; // final round, no MixColumns.
		else
			next_state = mix_columns(sr_out) ^ round_key;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			key_ok <= 1'b0;
			cnt <= '0;
			rnd <= '0;
			done <= 1'b0;
			data_out <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				run <= 1'b1;
				key_ok <= 1'b0;
				cnt <= '0;
			end else if (run) begin
				key_ok <= 1'b1; // ram output now tracks cnt one cycle behind.
				rnd <= cnt;
				if (cnt != rounds)
					cnt <= cnt + 1'b1;
				if (last_rnd) begin
					run <= 1'b0;
					key_ok <= 1'b0;
					done <= 1'b1;
					data_out <= next_state;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			state <= data_in;
		else if (key_ok)
			state <= next_state;
	end

endmodule

// ==== source/decipher.sv ====
module decipher (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                start,
	input  logic [aes_sizes_pkg::addr_bits-1:0] rounds,
	input  logic [aes_sizes_pkg::blk_bits-1:0]  data_in,
	input  logic [aes_sizes_pkg::blk_bits-1:0]  round_key,
	output logic [aes_sizes_pkg::addr_bits-1:0] key_addr,
	output logic [aes_sizes_pkg::blk_bits-1:0]  data_out,
	output logic                                done
);

	import aes_sizes_pkg::*;
	import aes_math_pkg::*;

	logic [blk_bits-1:0]  state;
	logic [blk_bits-1:0]  isr_out;
	logic [blk_bits-1:0]  next_state;
	logic [addr_bits-1:0] cnt; // steps issued, keys are read from the top.
	logic [addr_bits-1:0] rnd; // step whose key is on round_key.
	logic                 run;
	logic                 key_ok;
	logic                 last_rnd;

	assign key_addr = rounds - cnt;

	// InvShiftRows, InvSubBytes, AddRoundKey.
	assign isr_out = inv_sub_bytes(inv_shift_rows(state)) ^ round_key;
	assign last_rnd = key_ok && (rnd == rounds);

	always_comb begin
		if (rnd == '0)
			next_state = state ^ round_key; // round key N.
		else if (rnd == rounds)
			next_state = isr_out; // round key 0 ends the block.
		else
			next_state = inv_mix_columns(isr_out);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			key_ok <= 1'b0;
			cnt <= '0;
			rnd <= '0;
			done <= 1'b0;
			data_out <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				run <= 1'b1;
				key_ok <= 1'b0;
				cnt <= '0;
			end else if (run) begin
				key_ok <= 1'b1;
				rnd <= cnt;
				if (cnt != rounds)
					cnt <= cnt + 1'b1; // stops at key 0.
				if (last_rnd) begin
					run <= 1'b0;
					key_ok <= 1'b0;
					done <= 1'b1;
					data_out <= next_state;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			state <= data_in;
		else if (key_ok)
			state <= next_state;
	end

endmodule

// ==== source/key_expansion.sv ====
module key_expansion (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                start,
	input  aes_sizes_pkg::key_len_t             key_len,
	input  logic [aes_sizes_pkg::key_bits-1:0]  key,
	output logic [aes_sizes_pkg::blk_bits-1:0]  wdata,
	output logic [aes_sizes_pkg::addr_bits-1:0] addr,
	output logic                                we,
	output logic                                done
);

	import aes_sizes_pkg::*;
	import aes_math_pkg::*;

	logic [blk_bits-1:0]  cur; // round key being written.
	logic [blk_bits-1:0]  nxt; // the one after it, aes-256 only.
	logic [blk_bits-1:0]  gen;
	logic [word_bits-1:0] src_word;
	logic [word_bits-1:0] tmp;
	logic [addr_bits-1:0] cnt;
	logic [addr_bits-1:0] last;
	logic [addr_bits-1:0] rc_idx;
	logic                 rot_rule;
	logic                 run;
	logic                 fin;

	assign last = (key_len == key_len_128) ? addr_bits'(nr_128) : addr_bits'(nr_256);

	// aes-256 uses SubWord alone on every other group.
	assign rot_rule = (key_len == key_len_128) || !cnt[0];
	assign rc_idx = (key_len == key_len_128) ? cnt + 1'b1 : (cnt >> 1) + 1'b1;

	assign src_word = (key_len == key_len_128) ? cur[word_bits-1:0] : nxt[word_bits-1:0];
	assign tmp = rot_rule ? sub_word(rot_word(src_word)) ^ {rcon(rc_idx), 24'h000000}
		: sub_word(src_word);

	// each new word is the word four (or eight) back xor the previous one.
	assign gen[127:96] = cur[127:96] ^ tmp;
	assign gen[95:64] = cur[95:64] ^ gen[127:96];
	assign gen[63:32] = cur[63:32] ^ gen[95:64];
	assign gen[31:0] = cur[31:0] ^ gen[63:32];

	assign wdata = cur;
	assign addr = cnt;
	assign we = run;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			fin <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			done <= fin; // one idle cycle after the last write.
			fin <= 1'b0;
			if (start) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				if (cnt == last) begin
					run <= 1'b0;
					fin <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			cur <= key[key_bits-1 -: blk_bits];
			nxt <= key[blk_bits-1:0];
		end else if (run) begin
			if (key_len == key_len_128) begin
				cur <= gen;
			end else begin
				cur <= nxt;
				nxt <= gen;
			end
		end
	end

endmodule

// ==== source/round_key_ram.sv ====
module round_key_ram (
	input  logic                                clk,
	input  logic [aes_sizes_pkg::addr_bits-1:0] addr,
	input  logic [aes_sizes_pkg::blk_bits-1:0]  wdata,
	input  logic                                we,
	output logic [aes_sizes_pkg::blk_bits-1:0]  rdata
);

	import aes_sizes_pkg::*;

	logic [blk_bits-1:0] mem [ram_depth]; // one entry per round key.

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr]; // registered read, one cycle of latency.
	end

endmodule
